// ==== logic/cart_defines.svh ====
/*
 * shared widths and constants for the cartridge mapper
 * header offsets are even download word addresses, the byte of interest
 * sits in the low or high half of the word as noted below
 */
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

// ------------------------------------------------------------------------
// bus widths
`define CART_ADDR_W     16     // cpu cartridge address
`define CART_DATA_W     8      // cpu data
`define ROM_WADDR_W     22     // 10 bit bank field over 12 in-bank word bits
`define ROM_DATA_W      16     // external rom word
`define CRAM_ADDR_W     17     // byte address into 128 KB cart ram
`define LANE_ADDR_W     16     // word address inside one ram byte lane
`define NUM_LANES       2
`define DL_ADDR_W       25     // download byte address
`define DL_DATA_W       16
`define ROM_BANK_W      9      // mbc5 needs all 9, the others use 7
`define RAM_BANK_W      4      // 16 x 8 KB banks at most

// ------------------------------------------------------------------------
// header word offsets within the image
`define HDR_CGB_OFS     25'h142 // cgb flag in high byte, not decoded here
`define HDR_TYPE_OFS    25'h146 // cartridge type in high byte
`define HDR_SIZE_OFS    25'h148 // rom size low byte, ram size high byte

`define RAM_ENABLE_KEY  4'hA   // low nibble written to 0x0000-0x1FFF

`endif

// ==== logic/cart_pkg.sv ====
/*
 * types shared by the mapper blocks
 * region codes are the top three bits of the cpu cartridge address,
 * codes 0-3 are register writes and rom reads at the same time
 */
`default_nettype none

package cart_pkg;

	// ------------------------------------------------------------------------
	// mapper kind, decoded once from the header type byte
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0,        // plain 32 KB rom
		MBC_1    = 3'd1,        // types 0x01-0x03
		MBC_2    = 3'd2,        // types 0x05-0x06, 512 x 4 bit ram
		MBC_3    = 3'd3,        // types 0x0F-0x13
		MBC_5    = 3'd4         // types 0x19-0x1E
	} mbc_kind_t;

	// ------------------------------------------------------------------------
	// cpu address region, cart_addr[15:13]
	typedef enum logic [2:0] {
		REG_RAM_EN   = 3'd0,    // 0x0000, ram enable key
		REG_ROM_BANK = 3'd1,    // 0x2000, rom bank select
		REG_RAM_BANK = 3'd2,    // 0x4000, ram bank / rtc select
		REG_MODE     = 3'd3,    // 0x6000, mbc1 banking mode
		ROM_LOW      = 3'd4,    // 0x8000, off cartridge on a real bus
		CRAM         = 3'd5,    // 0xA000, cart ram window
		ROM_HIGH     = 3'd6,    // 0xC000, off cartridge
		OTHER        = 3'd7     // 0xE000 and up
	} cpu_region_t;

endpackage

`default_nettype wire

// ==== logic/cart_header.sv ====
/*
 * snoops the rom download for the type and size bytes
 * unknown rom size codes fall back to 128 banks, unknown ram codes to 16
 * cart_ready rises once the first download ends and only reset drops it
 */
`timescale 1ns/100ps
`default_nettype none
`include "cart_defines.svh"

module cart_header
	import cart_pkg::*;
(
	input  wire logic                     clk_sys,
	input  wire logic                     reset,
	input  wire logic                     dl_active,   // level for the whole image
	input  wire logic                     dl_wr,       // one pulse per word
	input  wire logic [`DL_ADDR_W-1:0]    dl_addr,
	input  wire logic [`DL_DATA_W-1:0]    dl_data,
	output mbc_kind_t                     mbc_kind,
	output logic      [`ROM_BANK_W-1:0]   rom_mask,
	output logic      [`RAM_BANK_W-1:0]   ram_mask,
	output logic                          cart_ready
);

	logic [7:0] type_byte;                 // header 0x147
	logic [7:0] rom_size;                  // header 0x148
	logic [7:0] ram_size;                  // header 0x149
	logic       dl_active_q;               // for the falling edge
	logic [`ROM_BANK_W:0] rom_mask_wide;   // one spare bit for the shift

	// ------------------------------------------------------------------------
	// capture
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte   <= 8'h00;
			rom_size    <= 8'h00;
			ram_size    <= 8'h00;
			dl_active_q <= 1'b0;
			cart_ready  <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active && dl_wr) begin
				case (dl_addr)
					`HDR_TYPE_OFS: type_byte <= dl_data[15:8];
					`HDR_SIZE_OFS: {ram_size, rom_size} <= dl_data;
					default: ;
				endcase
			end
			if (dl_active_q && !dl_active)
				cart_ready <= 1'b1;            // sticky
		end
	end

	// ------------------------------------------------------------------------
	// decode
	always_comb begin
		case (type_byte)
			8'h01, 8'h02, 8'h03:                      mbc_kind = MBC_1;
			8'h05, 8'h06:                             mbc_kind = MBC_2;
			8'h0F, 8'h10, 8'h11, 8'h12, 8'h13:        mbc_kind = MBC_3;
			8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E: mbc_kind = MBC_5;
			default:                                  mbc_kind = MBC_NONE;
		endcase
	end

	// code n means 2^(n+1) banks, so the mask is (2 << n) - 1
	assign rom_mask_wide = (10'd2 << rom_size[3:0]) - 10'd1;
	assign rom_mask      = (rom_size <= 8'd8) ? rom_mask_wide[`ROM_BANK_W-1:0] : 9'h07F;

	always_comb begin
		if (ram_size <= 8'd2)
			ram_mask = 4'h0;                   // none, 2 KB or one 8 KB bank
		else if (ram_size == 8'd3)
			ram_mask = 4'h3;                   // 32 KB
		else
			ram_mask = 4'hF;                   // 128 KB
	end

	// the loader only strobes words inside an image
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> dl_active);

endmodule

`default_nettype wire

// ==== logic/mbc_regs.sv ====
/*
 * mapper control registers, written by the cpu on cpu_ce
 * one write decode covers all mappers, rtc_select only moves for mbc3
 * and mbc1_mode only for mbc1; every register sits at reset during download
 */
`timescale 1ns/100ps
`default_nettype none
`include "cart_defines.svh"

module mbc_regs
	import cart_pkg::*;
(
	input  wire logic                     clk_sys,
	input  wire logic                     reset,
	input  wire logic                     dl_active,
	input  wire logic                     cpu_ce,
	input  wire logic [`CART_ADDR_W-1:0]  cart_addr,
	input  wire logic                     cart_wr,
	input  wire logic [`CART_DATA_W-1:0]  cart_di,
	input  wire mbc_kind_t                mbc_kind,
	output logic      [`ROM_BANK_W-1:0]   rom_bank,
	output logic      [`RAM_BANK_W-1:0]   ram_bank,
	output logic                          mbc1_mode,
	output logic                          rtc_select,
	output logic                          ram_enable
);

	cpu_region_t region;
	logic        wr_en;

	assign region = cpu_region_t'(cart_addr[`CART_ADDR_W-1 -: 3]);
	assign wr_en  = cpu_ce && cart_wr;         // one cpu write, one update

	// ------------------------------------------------------------------------
	// register file
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank   <= 9'd1;                // bank 1 in the switchable window
			ram_bank   <= 4'd0;
			mbc1_mode  <= 1'b0;
			rtc_select <= 1'b0;
			ram_enable <= 1'b0;
		end else if (wr_en) begin
			case (region)
				REG_RAM_EN: begin
					ram_enable <= (cart_di[3:0] == `RAM_ENABLE_KEY);
				end

				REG_ROM_BANK: begin
					if (mbc_kind == MBC_5) begin
						if (cart_addr[12])
							rom_bank[8] <= cart_di[0];        // 0x3000-0x3FFF
						else
							rom_bank[7:0] <= cart_di;         // 0x2000-0x2FFF
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank <= 9'd1;                      // bank 0 reads as 1
					end else begin
						rom_bank <= {2'b00, cart_di[6:0]};
					end
				end

				REG_RAM_BANK: begin
					if (mbc_kind == MBC_3) begin
						if (cart_di[3]) begin
							rtc_select <= 1'b1;                // 0x08-0x0C pick a clock reg
						end else begin
							rtc_select <= 1'b0;
							ram_bank   <= {2'b00, cart_di[1:0]};
						end
					end else if (mbc_kind == MBC_5) begin
						ram_bank <= cart_di[3:0];
					end else begin
						ram_bank <= {2'b00, cart_di[1:0]};
					end
				end

				REG_MODE: begin
					if (mbc_kind == MBC_1)
						mbc1_mode <= cart_di[0];               // 1 = ram banking mode
				end

				default: ;                                 // reads only
			endcase
		end
	end

	// only mbc5 may select rom bank 0 in the upper window
	a_bank_not_zero: assert property (@(posedge clk_sys) disable iff (reset)
		(wr_en && !dl_active && mbc_kind != MBC_5) |=> (rom_bank != 9'd0));

endmodule

`default_nettype wire

// ==== logic/bank_mapper.sv ====
/*
 * combinational address map, cpu address plus bank registers in,
 * rom word address and cart ram lane address out
 * rom_addr is only meaningful for 0x0000-0x7FFF, ram lanes for 0xA000-0xBFFF
 */
`timescale 1ns/100ps
`default_nettype none
`include "cart_defines.svh"

module bank_mapper
	import cart_pkg::*;
(
	input  wire logic [`CART_ADDR_W-1:0]  cart_addr,
	input  wire logic                     cart_wr,
	input  wire logic                     cpu_ce,
	input  wire mbc_kind_t                mbc_kind,
	input  wire logic [`ROM_BANK_W-1:0]   rom_mask,
	input  wire logic [`RAM_BANK_W-1:0]   ram_mask,
	input  wire logic [`ROM_BANK_W-1:0]   rom_bank,
	input  wire logic [`RAM_BANK_W-1:0]   ram_bank,
	input  wire logic                     mbc1_mode,
	output logic      [`ROM_WADDR_W-1:0]  rom_addr,
	output logic      [`LANE_ADDR_W-1:0]  lane_addr,
	output logic      [`NUM_LANES-1:0]    lane_wr,
	output logic                          cram_sel,
	output logic                          mbc2_nibble
);

	logic [`ROM_BANK_W-1:0]  hi_bank;      // upper window bank, before masking
	logic [`ROM_BANK_W:0]    bank_field;   // 16 KB bank plus cart_addr[13]
	logic [`RAM_BANK_W-1:0]  cram_bank;
	logic [`CRAM_ADDR_W-1:0] cram_addr;
	logic                    wr_cram;

	// ------------------------------------------------------------------------
	// rom side
	always_comb begin
		case (mbc_kind)
			MBC_1:   hi_bank = mbc1_mode ? {4'd0, rom_bank[4:0]}        // mode 1
			                             : {2'd0, ram_bank[1:0], rom_bank[4:0]};
			MBC_5:   hi_bank = rom_bank;
			default: hi_bank = {2'd0, rom_bank[6:0]};                  // mbc2, mbc3
		endcase
	end

	always_comb begin
		if (mbc_kind == MBC_NONE) begin
			bank_field = {8'd0, cart_addr[14:13]};                     // linear 32 KB
		end else begin
			case (cart_addr[15:14])
				2'b00:   bank_field = {9'd0, cart_addr[13]};           // fixed bank 0
				2'b01:   bank_field = {hi_bank & rom_mask, cart_addr[13]};
				default: bank_field = '0;
			endcase
		end
	end

	assign rom_addr = {bank_field, cart_addr[12:1]};   // 16 bit words

	// ------------------------------------------------------------------------
	// cart ram side
	always_comb begin
		case (mbc_kind)
			MBC_1:   cram_bank = mbc1_mode ? {2'd0, ram_bank[1:0] & ram_mask[1:0]} : 4'd0;
			MBC_3:   cram_bank = {2'd0, ram_bank[1:0] & ram_mask[1:0]};
			MBC_5:   cram_bank = ram_bank & ram_mask;
			default: cram_bank = 4'd0;                 // mbc2 and plain carts
		endcase
	end

	assign cram_addr   = {cram_bank, cart_addr[12:0]};
	assign lane_addr   = cram_addr[`CRAM_ADDR_W-1:1];
	assign cram_sel    = (cpu_region_t'(cart_addr[`CART_ADDR_W-1 -: 3]) == CRAM);
	assign mbc2_nibble = (mbc_kind == MBC_2) && (cart_addr[15:9] == 7'b1010000);
	assign wr_cram     = cpu_ce && cart_wr && cram_sel;

	// even bytes in lane 0, odd bytes in lane 1
	always_comb begin
		for (int i = 0; i < `NUM_LANES; i++)
			lane_wr[i] = wr_cram && (cram_addr[0] == i[0]);
	end

endmodule

`default_nettype wire

// ==== logic/cram_lane.sv ====
/*
 * one byte lane of cart ram, 64K x 8, single port
 * read is registered and returns the old byte on a same-cycle write
 * contents are undefined until written
 */
`timescale 1ns/100ps
`default_nettype none
`include "cart_defines.svh"

module cram_lane (
	input  wire logic                     clk_sys,
	input  wire logic                     reset,
	input  wire logic                     wr,
	input  wire logic [`LANE_ADDR_W-1:0]  addr,
	input  wire logic [`CART_DATA_W-1:0]  data,
	output logic      [`CART_DATA_W-1:0]  q
);

	logic [`CART_DATA_W-1:0] mem [0:(2**`LANE_ADDR_W)-1];

	always_ff @(posedge clk_sys) begin
		if (wr)
			mem[addr] <= data;
		q <= mem[addr];                        // addr is sampled every cycle
	end

	// the cpu side must not touch ram while the system is held in reset
	a_no_wr_in_reset: assert property (@(posedge clk_sys)
		reset |-> !wr);

endmodule

`default_nettype wire

// ==== logic/cart_read_mux.sv ====
/*
 * builds the byte returned to the cpu, one cycle after cart_rd
 * request flags are frozen when cart_rd is seen, lane data arrives a
 * cycle later from the ram; cart_do then holds until the next read
 */
`timescale 1ns/100ps
`default_nettype none
`include "cart_defines.svh"

module cart_read_mux (
	input  wire logic                                   clk_sys,
	input  wire logic                                   reset,
	input  wire logic                                   cart_rd,
	input  wire logic [`CART_ADDR_W-1:0]                cart_addr,
	input  wire logic                                   cram_sel,
	input  wire logic                                   mbc2_nibble,
	input  wire logic                                   ram_enable,
	input  wire logic                                   rtc_select,
	input  wire logic                                   cart_ready,
	input  wire logic [`ROM_DATA_W-1:0]                 rom_data,
	input  wire logic [`NUM_LANES-1:0][`CART_DATA_W-1:0] lane_q,
	output logic      [`CART_DATA_W-1:0]                cart_do
);

	localparam int LANE_SEL_W = $clog2(`NUM_LANES);

	logic                    rd_q;         // result due this cycle
	logic                    ready_q, cram_q, enable_q, rtc_q, nibble_q;
	logic [LANE_SEL_W-1:0]   lane_sel_q;
	logic [`CART_DATA_W-1:0] rom_byte_q, lane_byte, fresh_do, hold_do;

	// ------------------------------------------------------------------------
	// request capture
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q     <= 1'b0;
			ready_q  <= 1'b0;
			cram_q   <= 1'b0;
			enable_q <= 1'b0;
			rtc_q    <= 1'b0;
			nibble_q <= 1'b0;
			hold_do  <= 8'h00;
		end else begin
			rd_q <= cart_rd;
			if (cart_rd) begin
				ready_q  <= cart_ready;
				cram_q   <= cram_sel;
				enable_q <= ram_enable;
				rtc_q    <= rtc_select;
				nibble_q <= mbc2_nibble;
			end
			if (rd_q)
				hold_do <= fresh_do;           // keep it past the read cycle
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_rd) begin
			lane_sel_q <= cart_addr[LANE_SEL_W-1:0];   // ram byte address bit 0
			rom_byte_q <= cart_addr[0] ? rom_data[15:8] : rom_data[7:0];
		end
	end

	// ------------------------------------------------------------------------
	// result
	assign lane_byte = lane_q[lane_sel_q];

	always_comb begin
		if (!ready_q)
			fresh_do = 8'h00;                  // nothing downloaded yet
		else if (!cram_q)
			fresh_do = rom_byte_q;
		else if (!enable_q)
			fresh_do = 8'hFF;                  // open bus while disabled
		else if (rtc_q)
			fresh_do = 8'h00;                  // clock registers not modelled
		else if (nibble_q)
			fresh_do = {4'hF, lane_byte[3:0]}; // mbc2 ram is 4 bits wide
		else
			fresh_do = lane_byte;
	end

	assign cart_do = rd_q ? fresh_do : hold_do;

endmodule

`default_nettype wire

// ==== logic/gb_cart.sv ====
/*
 * game boy cartridge mapper top, mbc1/2/3/5 with up to 128 KB cart ram
 * rom sits outside, rom_data must answer rom_addr in the same cycle
 * cpu writes count only with cpu_ce high
 */
`timescale 1ns/100ps
`default_nettype none
`include "cart_defines.svh"

module gb_cart
	import cart_pkg::*;
(
	input  wire logic                     clk_sys,
	input  wire logic                     reset,
	// image download
	input  wire logic                     dl_active,
	input  wire logic                     dl_wr,
	input  wire logic [`DL_ADDR_W-1:0]    dl_addr,
	input  wire logic [`DL_DATA_W-1:0]    dl_data,
	// cpu cartridge bus
	input  wire logic                     cpu_ce,
	input  wire logic [`CART_ADDR_W-1:0]  cart_addr,
	input  wire logic                     cart_rd,
	input  wire logic                     cart_wr,
	input  wire logic [`CART_DATA_W-1:0]  cart_di,
	output logic      [`CART_DATA_W-1:0]  cart_do,
	// external rom
	output logic      [`ROM_WADDR_W-1:0]  rom_addr,
	input  wire logic [`ROM_DATA_W-1:0]   rom_data
);

	mbc_kind_t                                 mbc_kind;
	logic [`ROM_BANK_W-1:0]                    rom_mask, rom_bank;
	logic [`RAM_BANK_W-1:0]                    ram_mask, ram_bank;
	logic                                      cart_ready, mbc1_mode, rtc_select, ram_enable;
	logic [`LANE_ADDR_W-1:0]                   lane_addr;
	logic [`NUM_LANES-1:0]                     lane_wr;
	logic [`NUM_LANES-1:0][`CART_DATA_W-1:0]   lane_q;
	logic                                      cram_sel, mbc2_nibble;

	cart_header u_header (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data,
		.mbc_kind, .rom_mask, .ram_mask, .cart_ready
	);

	mbc_regs u_regs (
		.clk_sys, .reset, .dl_active, .cpu_ce, .cart_addr, .cart_wr, .cart_di,
		.mbc_kind, .rom_bank, .ram_bank, .mbc1_mode, .rtc_select, .ram_enable
	);

	bank_mapper u_mapper (
		.cart_addr, .cart_wr, .cpu_ce, .mbc_kind, .rom_mask, .ram_mask,
		.rom_bank, .ram_bank, .mbc1_mode,
		.rom_addr, .lane_addr, .lane_wr, .cram_sel, .mbc2_nibble
	);

	// ------------------------------------------------------------------------
	// cart ram, one instance per byte lane
	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
		cram_lane u_lane (
			.clk_sys,
			.reset,
			.wr   (lane_wr[g]),
			.addr (lane_addr),
			.data (cart_di),
			.q    (lane_q[g])
		);
	end

	cart_read_mux u_rdmux (
		.clk_sys, .reset, .cart_rd, .cart_addr, .cram_sel, .mbc2_nibble,
		.ram_enable, .rtc_select, .cart_ready, .rom_data, .lane_q, .cart_do
	);

endmodule

`default_nettype wire

// ==== testbench/tb_gb_cart.sv ====
/*
 * lfsr driven stimulus on the cartridge mapper checked against a reference model
 * rom is a mixing function of rom_addr and cart ram is mirrored in an array
 * cart ram bytes never written are not compared and reads and writes never share a cycle
 */
`timescale 1ns/100ps
`default_nettype none
`include "cart_defines.svh"

module tb_gb_cart;

	logic                     clk_sys, reset;
	logic                     dl_active, dl_wr;
	logic [`DL_ADDR_W-1:0]    dl_addr;
	logic [`DL_DATA_W-1:0]    dl_data;
	logic                     cpu_ce, cart_rd, cart_wr;
	logic [`CART_ADDR_W-1:0]  cart_addr;
	logic [`CART_DATA_W-1:0]  cart_di, cart_do;
	logic [`ROM_WADDR_W-1:0]  rom_addr;
	logic [`ROM_DATA_W-1:0]   rom_data;

	logic [31:0] lfsr = 32'hb037;
	int          errors, checks;
	bit          stuck;                    // a download never completed
	string       test_name;
	logic        chk_due, exp_known;       // pending result and whether it is defined
	logic [7:0]  exp_val;

	// ------------------------------------------------------------------------
	// reference model state
	int          m_kind;                   // 0 plain, 1 mbc1, 2 mbc2, 3 mbc3, 5 mbc5
	logic [8:0]  m_rom_mask, m_rom_bank;
	logic [3:0]  m_ram_mask, m_ram_bank;
	logic        m_mode, m_rtc, m_ram_en, m_ready;
	logic [7:0]  m_ram [0:131071];
	bit          m_valid [0:131071];

	gb_cart UUT (.*);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [15:0] rom_word(input logic [21:0] a);
		return {a[7:0] ^ a[21:14] ^ 8'h3C, a[15:8] ^ {a[5:0], a[21:20]} ^ 8'hA5};
	endfunction

	assign rom_data = rom_word(rom_addr);  // same-cycle rom

	// fibonacci lfsr on taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] want,
			input logic [31:0] got);
		checks++;
		if (want !== got) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h at %0t", name, want, got, $time);
		end
	endtask

	function automatic int kind_of(input logic [7:0] t);
		if (t >= 8'h01 && t <= 8'h03) return 1;
		if (t == 8'h05 || t == 8'h06) return 2;
		if (t >= 8'h0F && t <= 8'h13) return 3;
		if (t >= 8'h19 && t <= 8'h1E) return 5;
		return 0;
	endfunction

	// 16 KB bank number times 8K words plus the word inside the bank
	function automatic logic [21:0] rom_index(input logic [15:0] a);
		int bank;
		case (m_kind)
			0:       return 22'(a[14:1]);      // linear 32 KB
			1:       bank = int'(m_rom_bank[4:0]) + (m_mode ? 0 : int'(m_ram_bank[1:0]) * 32);
			5:       bank = int'(m_rom_bank);
			default: bank = int'(m_rom_bank[6:0]);
		endcase
		if (!a[14])
			bank = 0;                          // fixed low window
		bank = bank & int'(m_rom_mask);
		return 22'(bank * 8192 + int'(a[13:0]) / 2);
	endfunction

	function automatic int ram_index(input logic [15:0] a);
		logic [3:0] b;
		case (m_kind)
			1:       b = m_mode ? (m_ram_bank & m_ram_mask & 4'h3) : 4'h0;
			3:       b = m_ram_bank & m_ram_mask & 4'h3;
			5:       b = m_ram_bank & m_ram_mask;
			default: b = 4'h0;
		endcase
		return int'(b) * 8192 + int'(a[12:0]);
	endfunction

	task automatic model_read(input logic [15:0] a, output logic [7:0] e, output logic k);
		logic [15:0] w;
		int          i;
		k = 1'b1;
		w = rom_word(rom_index(a));
		i = ram_index(a);
		if (!m_ready)
			e = 8'h00;
		else if (a[15:13] != 3'b101)
			e = a[0] ? w[15:8] : w[7:0];
		else if (!m_ram_en)
			e = 8'hFF;
		else if (m_rtc)
			e = 8'h00;
		else begin
			e = m_ram[i];
			k = m_valid[i];
			if (m_kind == 2 && a < 16'hA200)
				e[7:4] = 4'hF;                 // 4 bit ram
		end
	endtask

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		int i;
		i = ram_index(a);
		case (a[15:13])
			3'd0: m_ram_en = (d[3:0] == 4'hA);
			3'd1: begin
				if (m_kind == 5 && a[12])
					m_rom_bank[8] = d[0];
				else if (m_kind == 5)
					m_rom_bank[7:0] = d;
				else
					m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
			end
			3'd2: begin
				if (m_kind == 3)
					m_rtc = d[3];
				if (m_kind == 5)
					m_ram_bank = d[3:0];
				else if (!(m_kind == 3 && d[3]))
					m_ram_bank = {2'b00, d[1:0]};  // rtc select leaves the bank alone
			end
			3'd3: if (m_kind == 1) m_mode = d[0];
			3'd5: begin
				m_ram[i]   = d;
				m_valid[i] = 1'b1;
			end
			default: ;
		endcase
	endtask

	// ------------------------------------------------------------------------
	// bus drivers
	task automatic bus_cycle(input logic rd, input logic wr, input logic ce,
			input logic [15:0] a, input logic [7:0] d);
		logic [7:0] e;
		logic       k;
		if (stuck) return;
		e         = 8'h00;
		k         = 1'b0;
		cart_rd   = rd;
		cart_wr   = wr;
		cpu_ce    = ce;
		cart_addr = a;
		cart_di   = d;
		if (rd)
			model_read(a, e, k);
		if (rd && !a[15]) begin
			@(negedge clk_sys);                // word address settled mid cycle
			check({test_name, "_rom_addr"}, 32'(rom_index(a)), 32'(rom_addr));
		end
		@(posedge clk_sys);
		if (wr && ce)
			model_write(a, d);                 // dut registers move on this edge
		if (rd) begin
			chk_due   = 1'b1;
			exp_val   = e;
			exp_known = k;
		end
		#1;
		cart_rd = 1'b0;
		cart_wr = 1'b0;
		cpu_ce  = 1'b0;
	endtask

	task automatic read_at(input logic [15:0] a);
		bus_cycle(1'b1, 1'b0, 1'b1, a, 8'h00);
	endtask

	task automatic write_at(input logic [15:0] a, input logic [7:0] d);
		bus_cycle(1'b0, 1'b1, 1'b1, a, d);
	endtask

	// header words around 0x140 carry the type at byte 0x147 and sizes at 0x148/0x149
	task automatic download(input logic [7:0] cart_type, input logic [7:0] rom_code,
			input logic [7:0] ram_code);
		int n;
		if (stuck) return;
		dl_active  = 1'b1;
		m_kind     = kind_of(cart_type);
		m_rom_bank = 9'd1;
		m_ram_bank = 4'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_ram_en   = 1'b0;
		for (int ofs = 'h13E; ofs <= 'h14E; ofs += 2) begin
			dl_wr   = 1'b1;
			dl_addr = 25'(ofs);
			dl_data = 16'(rand_bits(16));
			if (ofs == 'h146)
				dl_data = {cart_type, dl_data[7:0]};
			if (ofs == 'h148)
				dl_data = {ram_code, rom_code};
			@(posedge clk_sys);
			#1;
		end
		dl_wr = 1'b0;
		@(posedge clk_sys);
		#1 dl_active = 1'b0;
		m_rom_mask = (rom_code <= 8) ? 9'((2 << rom_code) - 1) : 9'h07F;
		m_ram_mask = (ram_code <= 2) ? 4'h0 : ((ram_code == 3) ? 4'h3 : 4'hF);
		n = 0;
		while (!UUT.cart_ready && n < 20) begin
			@(posedge clk_sys);
			#1 n++;
		end
		if (!UUT.cart_ready) begin
			$display("timeout: cart_ready stayed low 20 cycles after the download");
			stuck = 1'b1;
		end
		m_ready = 1'b1;
	endtask

	task automatic random_mix(input logic [7:0] cart_type, input logic [7:0] rom_code,
			input int ops);
		logic [1:0]  op;
		logic [15:0] a;
		logic [7:0]  d;
		logic        ce;
		test_name = $sformatf("random_type_%02h", cart_type);
		download(cart_type, rom_code, 8'h04);
		write_at(16'h0000, 8'h0A);
		for (int i = 0; i < ops; i++) begin
			op = 2'(rand_bits(2));
			d  = 8'(rand_bits(8));
			ce = (rand_bits(3) != 0);          // a few writes lose cpu_ce
			if (op[0])
				a = 16'hA000 | 16'(rand_bits(1) << 9) | 16'(rand_bits(4));
			else
				a = {1'b0, 15'(rand_bits(15))};
			if (op == 2'd2 && rand_bits(1) != 0)
				d = 8'h0A;                     // keeps ram enabled most of the time
			if (op[1])
				bus_cycle(1'b0, 1'b1, ce, a, d);
			else
				bus_cycle(1'b1, 1'b0, ce, a, d);   // back-to-back reads happen here
		end
	endtask

	// result is due one cycle after the request and held until the next one
	always @(negedge clk_sys) begin
		if (chk_due && exp_known && !stuck)
			check(test_name, exp_val, cart_do);
	end

	// ------------------------------------------------------------------------
	// sequence
	initial begin
		clk_sys    = 1'b0;
		reset      = 1'b1;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_addr    = '0;
		dl_data    = '0;
		cpu_ce     = 1'b0;
		cart_addr  = '0;
		cart_rd    = 1'b0;
		cart_wr    = 1'b0;
		cart_di    = '0;
		chk_due    = 1'b0;
		exp_known  = 1'b0;
		exp_val    = 8'h00;
		m_kind     = 0;
		m_ready    = 1'b0;
		m_rom_bank = 9'd1;
		m_ram_bank = 4'd0;
		m_rom_mask = 9'd1;
		m_ram_mask = 4'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_ram_en   = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1 reset = 1'b0;

		test_name = "no_download";
		for (int i = 0; i < 8; i++)
			read_at(16'(rand_bits(16)));
		test_name = "no_mapper";
		download(8'h00, 8'h00, 8'h00);
		write_at(16'h2000, 8'h02);             // ignored without a mapper
		for (int i = 0; i < 32; i++)
			read_at({1'b0, i[4:0], 10'(rand_bits(10))});

		test_name = "mbc1_bank0";
		download(8'h01, 8'h03, 8'h03);         // 256 KB rom, 32 KB ram
		write_at(16'h2000, 8'h03);
		write_at(16'h2000, 8'h00);
		read_at(16'h4000);
		read_at(16'h6001);
		test_name = "mbc1_wrap";
		write_at(16'h2100, 8'h1B);             // 27 wraps to 11
		read_at(16'h4002);
		read_at(16'h7FFF);
		test_name = "mbc1_mode0";
		download(8'h01, 8'h06, 8'h03);         // 2 MB so the upper bits show
		write_at(16'h2000, 8'h05);
		write_at(16'h4000, 8'h02);
		read_at(16'h4000);
		read_at(16'h5555);
		test_name = "mbc1_mode1";
		write_at(16'h6000, 8'h01);
		read_at(16'h4000);
		read_at(16'h5555);

		test_name = "mbc5_bank9";
		download(8'h19, 8'h08, 8'h04);         // 8 MB rom, 128 KB ram
		write_at(16'h2000, 8'h5A);
		write_at(16'h3000, 8'h01);
		read_at(16'h4000);
		read_at(16'h6AB3);
		test_name = "mbc5_ram_off";
		read_at(16'hA000);
		test_name = "mbc5_ram_banks";
		write_at(16'h0000, 8'h0A);
		for (int b = 0; b < 16; b++) begin
			write_at(16'h4000, 8'(b));
			write_at(16'hA010, 8'(b * 7 + 1));
			write_at(16'hA011, 8'(b ^ 'hC3));
		end
		for (int b = 0; b < 16; b++) begin
			write_at(16'h4000, 8'(b));
			read_at(16'hA010);                 // even lane
			read_at(16'hA011);                 // odd lane
		end

		test_name = "mbc3_rtc";
		download(8'h13, 8'h06, 8'h03);
		write_at(16'h0000, 8'h0A);
		write_at(16'h4000, 8'h02);
		write_at(16'hA123, 8'h77);
		read_at(16'hA123);
		write_at(16'h4000, 8'h08);             // clock register reads 0
		read_at(16'hA123);
		write_at(16'h4000, 8'h02);
		read_at(16'hA123);
		test_name = "mbc2_nibble";
		download(8'h06, 8'h03, 8'h00);
		write_at(16'h0000, 8'h0A);
		write_at(16'hA005, 8'h3C);
		write_at(16'hA006, 8'h81);
		read_at(16'hA005);
		read_at(16'hA006);

		random_mix(8'h00, 8'h00, 300);
		random_mix(8'h03, 8'h06, 300);
		random_mix(8'h06, 8'h03, 300);
		random_mix(8'h13, 8'h06, 300);
		random_mix(8'h1B, 8'h08, 300);
		repeat (2) @(posedge clk_sys);

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0 && !stuck)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/cart_pkg.sv
logic/cart_header.sv
logic/mbc_regs.sv
logic/bank_mapper.sv
logic/cram_lane.sv
logic/cart_read_mux.sv
logic/gb_cart.sv
testbench/tb_gb_cart.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the cartridge mapper testbench with verilator and run it
# pass or fail is taken from the simulation log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module tb_gb_cart -o sim_tb_gb_cart

./obj_dir/sim_tb_gb_cart > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
